/* hdl/bp_cfg_pkg.sv */
`default_nettype none

package bp_cfg_pkg;

    ////////////////////////////////////////////////////
    // Table geometry
    ////////////////////////////////////////////////////

    // Global history length, must not exceed the PHT index width
    localparam int unsigned BP_GH_BITS = 6;
    // Gshare table index width
    localparam int unsigned BP_PHT_BITS = 6;
    // Direct-mapped BTB index width
    localparam int unsigned BP_BTB_BITS = 4;
    // Partial tag kept per BTB entry
    localparam int unsigned BP_TAG_BITS = 8;
    // Instructions are word aligned, low PC bits carry no information
    localparam int unsigned BP_ALIGN_BITS = 2;
    localparam int unsigned BP_PC_BITS = 32;

    localparam int unsigned BP_PHT_ENTRIES = 1 << BP_PHT_BITS;
    localparam int unsigned BP_BTB_ENTRIES = 1 << BP_BTB_BITS;

    // Training queue depth, equal to the retire credit count
    localparam int unsigned BP_TRAIN_DEPTH = 4;
    localparam int unsigned BP_TRAIN_PTR_BITS = $clog2(BP_TRAIN_DEPTH);

    ////////////////////////////////////////////////////
    // Vector types
    ////////////////////////////////////////////////////

    typedef logic [BP_PC_BITS-1:0] bp_pc_t;
    typedef logic [BP_GH_BITS-1:0] bp_ghr_t;
    typedef logic [BP_PHT_BITS-1:0] bp_pht_idx_t;
    typedef logic [BP_BTB_BITS-1:0] bp_btb_idx_t;
    typedef logic [BP_TAG_BITS-1:0] bp_tag_t;
    // Queue pointers wrap on their own, depth is a power of two
    typedef logic [BP_TRAIN_PTR_BITS-1:0] bp_train_ptr_t;
    // One extra bit so a full queue is distinct from an empty one
    typedef logic [BP_TRAIN_PTR_BITS:0] bp_train_cnt_t;

endpackage

`default_nettype wire

/* hdl/bp_state_pkg.sv */
`default_nettype none

package bp_state_pkg;

    // Two-bit saturating counter
    // Upper bit is the predicted direction
    typedef enum logic [1:0] {
        BP_STRONG_NOT_TAKEN = 2'b00,
        BP_WEAK_NOT_TAKEN   = 2'b01,
        BP_WEAK_TAKEN       = 2'b10,
        BP_STRONG_TAKEN     = 2'b11
    } bp_counter_t;

    // Controller phases
    // Clear sweeps the tables, run serves fetch and retire
    typedef enum logic {
        BP_CTRL_CLEAR = 1'b0,
        BP_CTRL_RUN   = 1'b1
    } bp_ctrl_state_t;

endpackage

`default_nettype wire

/* hdl/bp_train_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface bp_train_if import bp_cfg_pkg::*; ();

    // One resolved branch per cycle
    // No ready, the tables always accept a valid entry
    logic    valid;
    bp_pc_t  pc;
    // History the branch was predicted with
    bp_ghr_t ghr_snapshot;
    logic    taken;
    bp_pc_t  target;

    // Queue side
    modport source (output valid, pc, ghr_snapshot, taken, target);

    // PHT and BTB side
    modport sink (input valid, pc, ghr_snapshot, taken, target);

endinterface

`default_nettype wire

/* hdl/bp_train_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module bp_train_queue import bp_cfg_pkg::*; (
    input  logic    clock,
    input  logic    reset,
    input  logic    push_valid_i,
    input  bp_pc_t  push_pc_i,
    input  bp_ghr_t push_ghr_i,
    input  logic    push_taken_i,
    input  bp_pc_t  push_target_i,
    input  logic    pop_enable_i,
    output logic    credit_o,
    bp_train_if.source train
);

    // Payload storage, one array per field
    bp_pc_t  pc_mem     [BP_TRAIN_DEPTH];
    bp_ghr_t ghr_mem    [BP_TRAIN_DEPTH];
    logic    taken_mem  [BP_TRAIN_DEPTH];
    bp_pc_t  target_mem [BP_TRAIN_DEPTH];

    bp_train_ptr_t wr_ptr;
    bp_train_ptr_t rd_ptr;
    bp_train_cnt_t count;
    logic          empty;
    logic          full;
    logic          pop;

    assign empty = (count == '0);
    assign full  = (count == bp_train_cnt_t'(BP_TRAIN_DEPTH));
    // Head leaves as soon as the controller allows it
    assign pop = !empty && pop_enable_i;

    // Head entry straight to the tables
    assign train.valid        = pop;
    assign train.pc           = pc_mem[rd_ptr];
    assign train.ghr_snapshot = ghr_mem[rd_ptr];
    assign train.taken        = taken_mem[rd_ptr];
    assign train.target       = target_mem[rd_ptr];

    // Every applied entry hands one credit back to retire
    assign credit_o = pop;

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_valid_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Occupancy only moves when exactly one side is active
            case ({push_valid_i, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (push_valid_i) begin
            pc_mem[wr_ptr]     <= push_pc_i;
            ghr_mem[wr_ptr]    <= push_ghr_i;
            taken_mem[wr_ptr]  <= push_taken_i;
            target_mem[wr_ptr] <= push_target_i;
        end
    end

    // Retire pushed without holding a credit
    a_no_overflow: assert property (
        @(posedge clock) disable iff (reset) push_valid_i |-> !full
    );

endmodule

`default_nettype wire

/* hdl/bp_sweep_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module bp_sweep_counter import bp_cfg_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  logic        enable_i,
    output bp_pht_idx_t index_o,
    output logic        last_o
);

    bp_pht_idx_t index_q;

    assign index_o = index_q;
    // PHT is the larger table, so its size sets the sweep length
    assign last_o = (index_q == bp_pht_idx_t'(BP_PHT_ENTRIES - 1));

    always_ff @(posedge clock) begin
        if (reset) begin
            index_q <= '0;
        end else if (enable_i && !last_o) begin
            index_q <= index_q + 1'b1;
        end
    end

    // Sweep enable drops once the final index is reached
    a_no_wrap: assert property (
        @(posedge clock) disable iff (reset) last_o |=> !enable_i
    );

endmodule

`default_nettype wire

/* hdl/bp_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module bp_ctrl import bp_state_pkg::*; (
    input  logic clock,
    input  logic reset,
    input  logic sweep_last_i,
    output logic sweep_enable_o,
    output logic clear_o,
    output logic ready_o,
    output logic pop_enable_o
);

    bp_ctrl_state_t state_q;
    bp_ctrl_state_t state_d;
    logic           in_clear;
    logic           in_run;

    ////////////////////////////////////////////////////
    // Next state
    ////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            // Leave once the last index is being written
            BP_CTRL_CLEAR: if (sweep_last_i) state_d = BP_CTRL_RUN;
            BP_CTRL_RUN:   state_d = BP_CTRL_RUN;
            default:       state_d = BP_CTRL_CLEAR;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state_q <= BP_CTRL_CLEAR;
        end else begin
            state_q <= state_d;
        end
    end

    ////////////////////////////////////////////////////
    // Outputs, pure state decode
    ////////////////////////////////////////////////////

    assign in_clear = (state_q == BP_CTRL_CLEAR);
    assign in_run   = (state_q == BP_CTRL_RUN);

    assign sweep_enable_o = in_clear;
    assign clear_o        = in_clear;
    assign ready_o        = in_run;
    // Training waits in the queue until the tables are clean
    assign pop_enable_o   = in_run;

endmodule

`default_nettype wire

/* hdl/bp_history.sv */
`timescale 1ns/1ps
`default_nettype none

module bp_history import bp_cfg_pkg::*; (
    input  logic    clock,
    input  logic    reset,
    input  logic    shift_i,
    input  logic    shift_bit_i,
    input  logic    recover_valid_i,
    input  bp_ghr_t recover_ghr_i,
    input  logic    recover_taken_i,
    output bp_ghr_t ghr_o
);

    bp_ghr_t ghr_q;

    assign ghr_o = ghr_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            ghr_q <= '0;
        end else if (recover_valid_i) begin
            // Rebuild from the snapshot plus the resolved outcome
            // Any speculative shift this cycle is on the wrong path
            ghr_q <= {recover_ghr_i[BP_GH_BITS-2:0], recover_taken_i};
        end else if (shift_i) begin
            // Speculative update with the predicted direction
            ghr_q <= {ghr_q[BP_GH_BITS-2:0], shift_bit_i};
        end
    end

endmodule

`default_nettype wire

/* hdl/bp_pht.sv */
`timescale 1ns/1ps
`default_nettype none

module bp_pht import bp_cfg_pkg::*, bp_state_pkg::*; (
    input  logic        clock,
    input  logic        clear_i,
    input  bp_pht_idx_t clear_index_i,
    input  bp_pc_t      lookup_pc_i,
    input  bp_ghr_t     lookup_ghr_i,
    output logic        taken_o,
    bp_train_if.sink    train
);

    bp_counter_t pht_mem [BP_PHT_ENTRIES];
    bp_pht_idx_t lookup_idx;
    bp_pht_idx_t train_idx;
    bp_counter_t lookup_cnt;

    // Gshare hash, word bits of the PC xor the zero-extended history
    function automatic bp_pht_idx_t hash_index(bp_pc_t pc, bp_ghr_t ghr);
        return pc[BP_ALIGN_BITS +: BP_PHT_BITS] ^ bp_pht_idx_t'(ghr);
    endfunction

    // Saturating step toward the resolved direction
    function automatic bp_counter_t saturate(bp_counter_t cnt, logic taken);
        bp_counter_t next_cnt;
        case (cnt)
            BP_STRONG_NOT_TAKEN: next_cnt = taken ? BP_WEAK_NOT_TAKEN : BP_STRONG_NOT_TAKEN;
            BP_WEAK_NOT_TAKEN:   next_cnt = taken ? BP_WEAK_TAKEN : BP_STRONG_NOT_TAKEN;
            BP_WEAK_TAKEN:       next_cnt = taken ? BP_STRONG_TAKEN : BP_WEAK_NOT_TAKEN;
            BP_STRONG_TAKEN:     next_cnt = taken ? BP_STRONG_TAKEN : BP_WEAK_TAKEN;
            default:             next_cnt = BP_WEAK_NOT_TAKEN;
        endcase
        return next_cnt;
    endfunction

    // Lookup uses the live history, training the snapshot it was predicted with
    assign lookup_idx = hash_index(lookup_pc_i, lookup_ghr_i);
    assign train_idx  = hash_index(train.pc, train.ghr_snapshot);

    assign lookup_cnt = pht_mem[lookup_idx];
    // Direction is the counter MSB
    assign taken_o = lookup_cnt[1];

    // Single write port shared by the sweep and training
    always_ff @(posedge clock) begin
        if (clear_i) begin
            pht_mem[clear_index_i] <= BP_WEAK_NOT_TAKEN;
        end else if (train.valid) begin
            pht_mem[train_idx] <= saturate(pht_mem[train_idx], train.taken);
        end
    end

    // Controller keeps the queue closed for the whole sweep
    a_clear_train_excl: assert property (
        @(posedge clock) !(clear_i && train.valid)
    );

endmodule

`default_nettype wire

/* hdl/bp_btb.sv */
`timescale 1ns/1ps
`default_nettype none

module bp_btb import bp_cfg_pkg::*; (
    input  logic        clock,
    input  logic        clear_i,
    input  bp_pht_idx_t clear_index_i,
    input  bp_pc_t      lookup_pc_i,
    input  logic        lookup_taken_i,
    output bp_pc_t      target_o,
    bp_train_if.sink    train
);

    ////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////

    logic    valid_mem  [BP_BTB_ENTRIES];
    bp_tag_t tag_mem    [BP_BTB_ENTRIES];
    bp_pc_t  target_mem [BP_BTB_ENTRIES];

    bp_btb_idx_t lookup_idx;
    bp_tag_t     lookup_tag;
    bp_btb_idx_t fill_idx;
    bp_tag_t     fill_tag;
    bp_btb_idx_t clear_idx;
    logic        fill;
    logic        hit;

    // Index right above the alignment bits, tag right above the index
    assign lookup_idx = lookup_pc_i[BP_ALIGN_BITS +: BP_BTB_BITS];
    assign lookup_tag = lookup_pc_i[BP_ALIGN_BITS + BP_BTB_BITS +: BP_TAG_BITS];
    assign fill_idx   = train.pc[BP_ALIGN_BITS +: BP_BTB_BITS];
    assign fill_tag   = train.pc[BP_ALIGN_BITS + BP_BTB_BITS +: BP_TAG_BITS];

    // Sweep runs over the PHT range, low bits revisit every BTB slot
    assign clear_idx = clear_index_i[BP_BTB_BITS-1:0];

    // Only taken branches are worth a target
    assign fill = train.valid && train.taken;

    ////////////////////////////////////////////////////
    // Lookup
    ////////////////////////////////////////////////////

    assign hit = lookup_taken_i && valid_mem[lookup_idx] && (tag_mem[lookup_idx] == lookup_tag);
    // Miss or not taken gives zero
    assign target_o = hit ? target_mem[lookup_idx] : '0;

    ////////////////////////////////////////////////////
    // Write ports
    ////////////////////////////////////////////////////

    // Valid bits are the only state the sweep touches
    always_ff @(posedge clock) begin
        if (clear_i) begin
            valid_mem[clear_idx] <= 1'b0;
        end else if (fill) begin
            valid_mem[fill_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (fill) begin
            tag_mem[fill_idx]    <= fill_tag;
            target_mem[fill_idx] <= train.target;
        end
    end

endmodule

`default_nettype wire

/* hdl/bp_top.sv */
`timescale 1ns/1ps
`default_nettype none

module bp_top import bp_cfg_pkg::*; (
    input  logic    clock,
    input  logic    reset,
    // Fetch
    input  logic    predict_valid_i,
    input  logic    predict_used_i,
    input  bp_pc_t  predict_pc_i,
    output logic    predict_taken_o,
    output bp_pc_t  predict_target_o,
    output bp_ghr_t predict_ghr_o,
    // Retire training, credit based
    input  logic    train_valid_i,
    input  bp_pc_t  train_pc_i,
    input  bp_ghr_t train_ghr_i,
    input  logic    train_taken_i,
    input  bp_pc_t  train_target_i,
    output logic    train_credit_o,
    // Mispredict recovery
    input  logic    recover_valid_i,
    input  bp_ghr_t recover_ghr_i,
    input  logic    recover_taken_i,
    output logic    ready_o
);

    bp_train_if  train ();

    bp_pht_idx_t sweep_index;
    logic        sweep_last;
    logic        sweep_enable;
    logic        clear;
    logic        pop_enable;
    logic        request;
    logic        pht_taken;

    // No predictions until the tables are clean
    assign request = predict_valid_i && ready_o;
    assign predict_taken_o = request && pht_taken;

    bp_ctrl u_ctrl (
        .clock, .reset,
        .sweep_last_i   (sweep_last),
        .sweep_enable_o (sweep_enable),
        .clear_o        (clear),
        .ready_o        (ready_o),
        .pop_enable_o   (pop_enable)
    );

    bp_sweep_counter u_sweep (
        .clock, .reset,
        .enable_i (sweep_enable),
        .index_o  (sweep_index),
        .last_o   (sweep_last)
    );

    // Snapshot output is the history this prediction was hashed with
    bp_history u_history (
        .clock, .reset,
        .shift_i         (request && predict_used_i),
        .shift_bit_i     (predict_taken_o),
        .recover_valid_i (recover_valid_i),
        .recover_ghr_i   (recover_ghr_i),
        .recover_taken_i (recover_taken_i),
        .ghr_o           (predict_ghr_o)
    );

    bp_train_queue u_queue (
        .clock, .reset,
        .push_valid_i  (train_valid_i),
        .push_pc_i     (train_pc_i),
        .push_ghr_i    (train_ghr_i),
        .push_taken_i  (train_taken_i),
        .push_target_i (train_target_i),
        .pop_enable_i  (pop_enable),
        .credit_o      (train_credit_o),
        .train         (train.source)
    );

    bp_pht u_pht (
        .clock,
        .clear_i       (clear),
        .clear_index_i (sweep_index),
        .lookup_pc_i   (predict_pc_i),
        .lookup_ghr_i  (predict_ghr_o),
        .taken_o       (pht_taken),
        .train         (train.sink)
    );

    // Target is only looked up behind a taken direction
    bp_btb u_btb (
        .clock,
        .clear_i        (clear),
        .clear_index_i  (sweep_index),
        .lookup_pc_i    (predict_pc_i),
        .lookup_taken_i (predict_taken_o),
        .target_o       (predict_target_o),
        .train          (train.sink)
    );

endmodule

`default_nettype wire

/* tests/bp_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module bp_tb import bp_cfg_pkg::*; ();

    // Eight hex words per operation in the vector file
    localparam int VEC_WORDS      = 8;
    localparam int MAX_OPS        = 64;
    localparam int TIMEOUT_CYCLES = 200;

    localparam logic [3:0] OP_WAIT    = 4'h0;
    localparam logic [3:0] OP_PREDICT = 4'h1;
    localparam logic [3:0] OP_TRAIN   = 4'h2;
    localparam logic [3:0] OP_RECOVER = 4'h3;
    localparam logic [3:0] OP_END     = 4'hf;

    logic    clock;
    logic    reset;
    logic    predict_valid_i;
    logic    predict_used_i;
    bp_pc_t  predict_pc_i;
    logic    predict_taken_o;
    bp_pc_t  predict_target_o;
    bp_ghr_t predict_ghr_o;
    logic    train_valid_i;
    bp_pc_t  train_pc_i;
    bp_ghr_t train_ghr_i;
    logic    train_taken_i;
    bp_pc_t  train_target_i;
    logic    train_credit_o;
    logic    recover_valid_i;
    bp_ghr_t recover_ghr_i;
    logic    recover_taken_i;
    logic    ready_o;

    logic [31:0] vec_mem [VEC_WORDS*MAX_OPS];
    int          value_errors;
    int          protocol_errors;
    int          sent;
    int          returned;
    int          vec_num;
    bit          timed_out;

    bp_top UUT (.*);

    always #5 clock = ~clock;

    // Credit pulses seen by retire, sampled before the edge moves the queue
    always @(posedge clock) begin
        if (!reset && train_credit_o) begin
            if (!ready_o) begin
                protocol_errors++;
                $display("Credit returned while the tables were still being cleared");
            end
            returned++;
        end
    end

    ////////////////////////////////////////////////
    // Typed compares
    ////////////////////////////////////////////////

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            value_errors++;
            $display("[FAIL] %s vector %0d: got 0x%h, expected 0x%h",
                     name, vec_num, actual, expected);
        end
    endtask

    task automatic check_pc(input string name, input bp_pc_t actual, input bp_pc_t expected);
        if (actual !== expected) begin
            value_errors++;
            $display("[FAIL] %s vector %0d: got 0x%h, expected 0x%h",
                     name, vec_num, actual, expected);
        end
    endtask

    task automatic check_ghr(input string name, input bp_ghr_t actual, input bp_ghr_t expected);
        if (actual !== expected) begin
            value_errors++;
            $display("[FAIL] %s vector %0d: got 0x%h, expected 0x%h",
                     name, vec_num, actual, expected);
        end
    endtask

    ////////////////////////////////////////////////
    // Drivers and waits
    ////////////////////////////////////////////////

    task automatic drive_idle();
        predict_valid_i <= 1'b0;
        predict_used_i  <= 1'b0;
        train_valid_i   <= 1'b0;
        recover_valid_i <= 1'b0;
    endtask

    // Retire holds DEPTH credits minus the entries still in flight
    task automatic wait_for_credit();
        int cycles;
        cycles = 0;
        while ((sent - returned) >= int'(BP_TRAIN_DEPTH) && cycles < TIMEOUT_CYCLES) begin
            @(posedge clock);
            drive_idle();
            @(negedge clock);
            cycles++;
        end
        if ((sent - returned) >= int'(BP_TRAIN_DEPTH)) begin
            timed_out = 1'b1;
            $display("Timed out waiting for a training credit before vector %0d", vec_num);
        end
    endtask

    // Sweep length and quiet outputs while the tables clear
    // One not-taken entry is parked in the queue and has to wait for run
    task automatic check_sweep();
        int cycles;
        cycles = 0;
        train_valid_i  <= 1'b1;
        train_pc_i     <= 32'h0000_0080;
        train_ghr_i    <= '0;
        train_taken_i  <= 1'b0;
        train_target_i <= '0;
        sent++;
        @(negedge clock);
        while (!ready_o && cycles < 2 * int'(BP_PHT_ENTRIES)) begin
            check_bit("predict_taken_o", predict_taken_o, 1'b0);
            check_pc("predict_target_o", predict_target_o, '0);
            cycles++;
            @(posedge clock);
            train_valid_i <= 1'b0;
            @(negedge clock);
        end
        if (!ready_o) begin
            timed_out = 1'b1;
            $display("Timed out waiting for ready_o after reset");
        end else if (cycles != int'(BP_PHT_ENTRIES)) begin
            protocol_errors++;
            $display("ready_o rose %0d cycles after reset, expected %0d",
                     cycles, BP_PHT_ENTRIES);
        end
    endtask

    task automatic apply_vector(input int base);
        logic [3:0] op;
        logic       arg_bit;
        int         arg;
        logic       is_predict;
        op         = vec_mem[base][3:0];
        arg        = int'(vec_mem[base+1]);
        arg_bit    = vec_mem[base+1][0];
        is_predict = (op == OP_PREDICT) || (op == OP_RECOVER);
        if (op == OP_WAIT) begin
            repeat (arg) begin
                @(posedge clock);
                drive_idle();
                @(negedge clock);
            end
        end else begin
            if (op == OP_TRAIN) begin
                wait_for_credit();
            end
            if (!timed_out) begin
                @(posedge clock);
                predict_valid_i <= is_predict;
                // Recovery always comes with a used prediction in the same cycle
                predict_used_i  <= (op == OP_RECOVER) || (op == OP_PREDICT && arg_bit);
                predict_pc_i    <= vec_mem[base+2];
                train_valid_i   <= (op == OP_TRAIN);
                train_pc_i      <= vec_mem[base+2];
                train_ghr_i     <= bp_ghr_t'(vec_mem[base+3]);
                train_taken_i   <= arg_bit;
                train_target_i  <= vec_mem[base+4];
                recover_valid_i <= (op == OP_RECOVER);
                recover_ghr_i   <= bp_ghr_t'(vec_mem[base+3]);
                recover_taken_i <= arg_bit;
                if (op == OP_TRAIN) begin
                    sent++;
                end
                @(negedge clock);
                if (is_predict) begin
                    check_bit("predict_taken_o", predict_taken_o, vec_mem[base+5][0]);
                    check_pc("predict_target_o", predict_target_o, vec_mem[base+6]);
                    check_ghr("predict_ghr_o", predict_ghr_o, bp_ghr_t'(vec_mem[base+7]));
                end
            end
        end
    endtask

    task automatic replay_vectors();
        int op_idx;
        op_idx = 0;
        while (!timed_out && op_idx < MAX_OPS && vec_mem[op_idx*VEC_WORDS][3:0] != OP_END) begin
            vec_num = op_idx;
            apply_vector(op_idx * VEC_WORDS);
            op_idx++;
        end
        if (op_idx == MAX_OPS) begin
            protocol_errors++;
            $display("Vector file has no end marker");
        end
    endtask

    // Every entry sent must come back as exactly one credit
    task automatic drain_credits();
        int cycles;
        cycles = 0;
        @(posedge clock);
        drive_idle();
        @(negedge clock);
        while (returned != sent && cycles < TIMEOUT_CYCLES) begin
            @(negedge clock);
            cycles++;
        end
        repeat (2) @(negedge clock);
        if (returned != sent) begin
            protocol_errors++;
            $display("Sent %0d training entries but got %0d credits back", sent, returned);
        end
    endtask

    ////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////

    initial begin
        clock           = 1'b0;
        reset           = 1'b1;
        predict_valid_i = 1'b1;
        predict_used_i  = 1'b0;
        predict_pc_i    = 32'h0000_1234;
        train_valid_i   = 1'b0;
        train_pc_i      = '0;
        train_ghr_i     = '0;
        train_taken_i   = 1'b0;
        train_target_i  = '0;
        recover_valid_i = 1'b0;
        recover_ghr_i   = '0;
        recover_taken_i = 1'b0;
        value_errors    = 0;
        protocol_errors = 0;
        sent            = 0;
        returned        = 0;
        vec_num         = 0;
        timed_out       = 1'b0;
        $readmemh("tests/bp_input.txt", vec_mem);
        repeat (5) @(posedge clock);
        reset <= 1'b0;
        check_sweep();
        if (!timed_out) begin
            replay_vectors();
        end
        if (!timed_out) begin
            drain_credits();
        end
        $display("Errors: %0d value, %0d protocol, %0d timeout",
                 value_errors, protocol_errors, timed_out);
        if (value_errors == 0 && protocol_errors == 0 && !timed_out) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/bp_input.txt */
// Columns: op arg pc ghr target exp_taken exp_target exp_ghr, all hex
// op 0 wait arg cycles, 1 predict arg used, 2 train arg taken, 3 recover arg taken, f end
1 1 00000100 00 00000000 0 00000000 00
3 1 00000200 05 00000000 0 00000000 00
1 1 00000100 00 00000000 0 00000000 0b
1 0 00000100 00 00000000 0 00000000 16
1 1 00000100 00 00000000 0 00000000 16
1 0 00000104 00 00000000 0 00000000 2c
2 1 00001234 2c 00002000 0 00000000 00
2 1 00001234 2c 00002000 0 00000000 00
0 2 00000000 00 00000000 0 00000000 00
1 0 00001234 00 00000000 1 00002000 2c
1 0 00003234 00 00000000 1 00000000 2c
1 1 00001234 00 00000000 1 00002000 2c
1 0 00001234 00 00000000 0 00000000 19
3 0 00001234 2c 00000000 0 00000000 19
1 0 00001234 00 00000000 0 00000000 18
3 0 00001234 16 00000000 0 00000000 18
1 0 00001234 00 00000000 1 00002000 2c
2 0 00001234 2c 00000000 0 00000000 00
2 0 00001234 2c 00000000 0 00000000 00
0 2 00000000 00 00000000 0 00000000 00
1 0 00001234 00 00000000 0 00000000 2c
f 0 00000000 00 00000000 0 00000000 00

/* src.f */
hdl/bp_cfg_pkg.sv
hdl/bp_state_pkg.sv
hdl/bp_train_if.sv
hdl/bp_train_queue.sv
hdl/bp_sweep_counter.sv
hdl/bp_ctrl.sv
hdl/bp_history.sv
hdl/bp_pht.sv
hdl/bp_btb.sv
hdl/bp_top.sv
tests/bp_tb.sv

/* run_sim.sh */
#!/bin/sh
verilator --binary --timing -Wno-fatal --top-module bp_tb -f src.f -o bp_sim || exit 1
out=$(./obj_dir/bp_sim)
echo "$out"
echo "$out" | grep -q "TB PASSED" && exit 0 || exit 1
